/* source/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Core side widths
`define LSU_ADDR_W 32
`define LSU_REG_W 32

// AXI4 bus widths
`define AXI_DATA_W 64
`define AXI_STRB_W 8
`define AXI_ID_W 4
`define AXI_LEN_W 8
`define AXI_SIZE_W 3
`define AXI_BURST_W 2

// Burst encodings
`define AXI_BURST_FIXED 2'b00
`define AXI_BURST_INCR 2'b01

// Single beat, single ID
`define AXI_ID_ZERO 4'd0
`define AXI_LEN_SINGLE 8'd0

`endif

/* source/lsu_op_pkg.sv */
package lsu_op_pkg;

  // Decoded memory operation
  typedef enum logic [3:0] {
    LSU_NONE = 4'd0,
    LSU_LB   = 4'd1,
    LSU_LBU  = 4'd2,
    LSU_LH   = 4'd3,
    LSU_LHU  = 4'd4,
    LSU_LW   = 4'd5,
    LSU_SB   = 4'd6,
    LSU_SH   = 4'd7,
    LSU_SW   = 4'd8
  } lsu_op_e;

  typedef enum logic [1:0] {
    INST_OTHER = 2'd0,
    INST_LOAD  = 2'd1,
    INST_STORE = 2'd2
  } inst_type_e;

  // Same encoding as AxSIZE
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'b000,
    SIZE_HALF = 3'b001,
    SIZE_WORD = 3'b010
  } axi_size_e;

  // Classified request, shared by store and load paths
  typedef struct packed {
    lsu_op_e   op;
    logic      is_load;
    logic      is_store;
    logic [2:0] byte_off;
    logic      misaligned;
    axi_size_e size;
  } lsu_req_t;

endpackage

/* source/axi_chan_pkg.sv */
`include "lsu_consts.svh"

package axi_chan_pkg;

  // Address channel fields, common to AW and AR
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0]  addr;
    logic [`AXI_ID_W-1:0]    id;
    logic [`AXI_LEN_W-1:0]   len;
    logic [`AXI_SIZE_W-1:0]  size;
    logic [`AXI_BURST_W-1:0] burst;
  } axi_ax_t;

  // Write address group
  typedef axi_ax_t axi_aw_t;

  // Read address group
  typedef axi_ax_t axi_ar_t;

  // Write data group, one beat
  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } axi_w_t;

endpackage

/* source/lsu_addr_gen.sv */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_addr_gen (
  input  logic                    clock,
  input  logic                    reset,
  input  lsu_op_pkg::inst_type_e  inst_type_i,
  input  lsu_op_pkg::lsu_op_e     lsu_op_i,
  input  logic [`LSU_REG_W-1:0]   rs1_data_i,
  input  logic [`LSU_REG_W-1:0]   imm_i,
  output lsu_op_pkg::lsu_req_t    req_o,
  output axi_chan_pkg::axi_aw_t   aw_o,
  output axi_chan_pkg::axi_ar_t   ar_o,
  output logic                    misalign_o
);
  import lsu_op_pkg::*;
  import axi_chan_pkg::*;

  logic [`LSU_ADDR_W-1:0] addr;
  logic                   op_load;
  logic                   op_store;
  logic                   is_load;
  logic                   is_store;
  logic                   misaligned;
  axi_size_e              size;
  axi_ax_t                active_ax;
  axi_ax_t                idle_ax;

  assign addr = rs1_data_i + imm_i;

  // Direction and size from the opcode alone
  always_comb begin
    op_load = 1'b0;
    op_store = 1'b0;
    size = SIZE_BYTE;
    case (lsu_op_i)
      LSU_LB, LSU_LBU: begin
        op_load = 1'b1;
        size = SIZE_BYTE;
      end
      LSU_LH, LSU_LHU: begin
        op_load = 1'b1;
        size = SIZE_HALF;
      end
      LSU_LW: begin
        op_load = 1'b1;
        size = SIZE_WORD;
      end
      LSU_SB: begin
        op_store = 1'b1;
        size = SIZE_BYTE;
      end
      LSU_SH: begin
        op_store = 1'b1;
        size = SIZE_HALF;
      end
      LSU_SW: begin
        op_store = 1'b1;
        size = SIZE_WORD;
      end
      default: begin
        op_load = 1'b0;
        op_store = 1'b0;
      end
    endcase
  end

  // Opcode must agree with the instruction class, otherwise idle
  assign is_load  = reset && op_load && (inst_type_i == INST_LOAD);
  assign is_store = reset && op_store && (inst_type_i == INST_STORE);

  always_comb begin
    case (size)
      SIZE_HALF: misaligned = addr[0];
      SIZE_WORD: misaligned = |addr[1:0];
      default:   misaligned = 1'b0;
    endcase
  end

  always_comb begin
    req_o.op         = (is_load || is_store) ? lsu_op_i : LSU_NONE;
    req_o.is_load    = is_load;
    req_o.is_store   = is_store;
    req_o.byte_off   = (is_load || is_store) ? addr[2:0] : 3'b000;
    req_o.misaligned = (is_load || is_store) && misaligned;
    req_o.size       = (is_load || is_store) ? size : SIZE_BYTE;
  end

  assign misalign_o = req_o.misaligned;

  always_comb begin
    active_ax.addr  = addr;
    active_ax.id    = `AXI_ID_ZERO;
    active_ax.len   = `AXI_LEN_SINGLE;
    active_ax.size  = size;
    active_ax.burst = `AXI_BURST_INCR;
    idle_ax.addr    = '0;
    idle_ax.id      = `AXI_ID_ZERO;
    idle_ax.len     = `AXI_LEN_SINGLE;
    idle_ax.size    = SIZE_BYTE;
    idle_ax.burst   = `AXI_BURST_FIXED;
  end

  assign aw_o = is_store ? active_ax : idle_ax;
  assign ar_o = is_load ? active_ax : idle_ax;

  a_one_dir: assert property (@(posedge clock) disable iff (!reset)
    !((aw_o.burst == `AXI_BURST_INCR) && (ar_o.burst == `AXI_BURST_INCR)));

  a_byte_aligned: assert property (@(posedge clock) disable iff (!reset)
    req_o.misaligned |-> (req_o.size != SIZE_BYTE));

endmodule

/* source/lsu_store_format.sv */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_store_format (
  input  logic                  clock,
  input  lsu_op_pkg::lsu_req_t  req_i,
  input  logic [`LSU_REG_W-1:0] rs2_data_i,
  output axi_chan_pkg::axi_w_t  w_o
);
  import lsu_op_pkg::*;

  logic [`AXI_DATA_W-1:0] low_data;
  logic [`AXI_STRB_W-1:0] low_strb;
  logic [5:0]             bit_off;
  logic                   store_ok;

  // Operand and mask placed at lane 0 first
  always_comb begin
    low_data = '0;
    low_strb = '0;
    case (req_i.op)
      LSU_SB: begin
        low_data = {{(`AXI_DATA_W-8){1'b0}}, rs2_data_i[7:0]};
        low_strb = 8'b0000_0001;
      end
      LSU_SH: begin
        low_data = {{(`AXI_DATA_W-16){1'b0}}, rs2_data_i[15:0]};
        low_strb = 8'b0000_0011;
      end
      LSU_SW: begin
        low_data = {{(`AXI_DATA_W-`LSU_REG_W){1'b0}}, rs2_data_i};
        low_strb = 8'b0000_1111;
      end
      default: begin
        low_data = '0;
        low_strb = '0;
      end
    endcase
  end

  assign bit_off  = {req_i.byte_off, 3'b000};
  assign store_ok = req_i.is_store && !req_i.misaligned;

  // Aligned accesses never cross the 64-bit beat, so a plain shift is enough
  always_comb begin
    if (store_ok) begin
      w_o.data = low_data << bit_off;
      w_o.strb = low_strb << req_i.byte_off;
    end else begin
      w_o.data = '0;
      w_o.strb = '0;
    end
  end

  a_strb_pop: assert property (@(posedge clock)
    $countones(w_o.strb) inside {0, 1, 2, 4});

endmodule

/* source/lsu_load_align.sv */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_load_align (
  input  logic                   clock,
  input  logic                   reset,
  input  lsu_op_pkg::lsu_req_t   req_i,
  input  logic [`AXI_DATA_W-1:0] rdata_i,
  input  logic                   rdata_we_i,
  output logic [`LSU_REG_W-1:0]  mem_result_o
);
  import lsu_op_pkg::*;

  logic [`AXI_DATA_W-1:0] lane_data;
  logic [`LSU_REG_W-1:0]  load_val;
  logic                   load_ok;

  // Bring the addressed lane down to bit 0
  assign lane_data = rdata_i >> {req_i.byte_off, 3'b000};

  always_comb begin
    case (req_i.op)
      LSU_LB: begin
        load_val = {{(`LSU_REG_W-8){lane_data[7]}}, lane_data[7:0]};
      end
      LSU_LBU: begin
        load_val = {{(`LSU_REG_W-8){1'b0}}, lane_data[7:0]};
      end
      LSU_LH: begin
        load_val = {{(`LSU_REG_W-16){lane_data[15]}}, lane_data[15:0]};
      end
      LSU_LHU: begin
        load_val = {{(`LSU_REG_W-16){1'b0}}, lane_data[15:0]};
      end
      LSU_LW: begin
        load_val = lane_data[`LSU_REG_W-1:0];
      end
      default: begin
        load_val = '0;
      end
    endcase
  end

  // misaligned loads keep the old result
  assign load_ok = rdata_we_i && req_i.is_load && !req_i.misaligned;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      mem_result_o <= '0;
    end else if (load_ok) begin
      mem_result_o <= load_val;
    end
  end

  // Read data is only returned for an outstanding load
  a_we_on_load: assert property (@(posedge clock) disable iff (!reset)
    rdata_we_i |-> req_i.is_load);

endmodule

/* source/lsu_top.sv */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_top (
  input  logic                   clock,
  input  logic                   reset,
  input  lsu_op_pkg::inst_type_e inst_type_i,
  input  lsu_op_pkg::lsu_op_e    lsu_op_i,
  input  logic [`LSU_REG_W-1:0]  imm_i,
  input  logic [`LSU_REG_W-1:0]  rs1_data_i,
  input  logic [`LSU_REG_W-1:0]  rs2_data_i,
  input  logic [`AXI_DATA_W-1:0] rdata_i,
  input  logic                   rdata_we_i,
  output axi_chan_pkg::axi_aw_t  aw_o,
  output axi_chan_pkg::axi_w_t   w_o,
  output axi_chan_pkg::axi_ar_t  ar_o,
  output logic                   misalign_o,
  output logic [`LSU_REG_W-1:0]  mem_result_o
);
  import lsu_op_pkg::*;

  lsu_req_t req;

  // Address, size and channel fields
  lsu_addr_gen addr_gen0 (
    .clock       (clock),
    .reset       (reset),
    .inst_type_i (inst_type_i),
    .lsu_op_i    (lsu_op_i),
    .rs1_data_i  (rs1_data_i),
    .imm_i       (imm_i),
    .req_o       (req),
    .aw_o        (aw_o),
    .ar_o        (ar_o),
    .misalign_o  (misalign_o)
  );

  // Store data and strobes
  lsu_store_format store_format0 (
    .clock      (clock),
    .req_i      (req),
    .rs2_data_i (rs2_data_i),
    .w_o        (w_o)
  );

  // Load result for write-back
  lsu_load_align load_align0 (
    .clock        (clock),
    .reset        (reset),
    .req_i        (req),
    .rdata_i      (rdata_i),
    .rdata_we_i   (rdata_we_i),
    .mem_result_o (mem_result_o)
  );

endmodule

/* tests/lsu_top_tb.sv */
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_top_tb;
  import lsu_op_pkg::*;
  import axi_chan_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 3;
  localparam int MAX_ROWS     = 64;

  // One table entry, stimulus followed by expected responses
  typedef struct packed {
    lsu_op_e                op;
    inst_type_e             itype;
    logic [`LSU_REG_W-1:0]  rs1;
    logic [`LSU_REG_W-1:0]  imm;
    logic [`LSU_REG_W-1:0]  rs2;
    logic [`AXI_DATA_W-1:0] rdata;
    logic                   we;
    axi_aw_t                exp_aw;
    axi_ar_t                exp_ar;
    axi_w_t                 exp_w;
    logic                   exp_mis;
    logic [`LSU_REG_W-1:0]  exp_result;
  } row_t;

  logic                   clock = 1'b0;
  logic                   reset;
  inst_type_e             inst_type_i;
  lsu_op_e                lsu_op_i;
  logic [`LSU_REG_W-1:0]  imm_i;
  logic [`LSU_REG_W-1:0]  rs1_data_i;
  logic [`LSU_REG_W-1:0]  rs2_data_i;
  logic [`AXI_DATA_W-1:0] rdata_i;
  logic                   rdata_we_i;
  axi_aw_t                aw_o;
  axi_w_t                 w_o;
  axi_ar_t                ar_o;
  logic                   misalign_o;
  logic [`LSU_REG_W-1:0]  mem_result_o;

  row_t                   rows [0:MAX_ROWS-1];
  int                     n_rows = 0;
  int                     n_checks = 0;
  int                     n_errors = 0;
  int                     cur_row = -1;
  logic                   table_ready = 1'b0;
  logic [`LSU_REG_W-1:0]  model_result = '0;

  lsu_top dut0 (
    .clock        (clock),
    .reset        (reset),
    .inst_type_i  (inst_type_i),
    .lsu_op_i     (lsu_op_i),
    .imm_i        (imm_i),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .rdata_i      (rdata_i),
    .rdata_we_i   (rdata_we_i),
    .aw_o         (aw_o),
    .w_o          (w_o),
    .ar_o         (ar_o),
    .misalign_o   (misalign_o),
    .mem_result_o (mem_result_o)
  );

  always #(CLK_PERIOD/2) clock = ~clock;

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error: %s got %0h expected %0h (row %0d)", name, got, exp, cur_row);
    end
  endtask

  // Expected responses from the lane, strobe, extension and alignment rules
  task automatic build_expected(inout row_t r);
    logic [`LSU_ADDR_W-1:0] addr;
    logic [2:0]             off;
    int                     nbytes;
    int                     i;
    logic                   sign_ext;
    logic                   is_ld;
    logic                   is_st;
    logic                   mis;
    logic [`LSU_REG_W-1:0]  val;
    axi_ax_t                active_ax;

    addr = r.rs1 + r.imm;
    off = addr[2:0];
    is_ld = (r.itype == INST_LOAD) && (r.op == LSU_LB || r.op == LSU_LBU ||
            r.op == LSU_LH || r.op == LSU_LHU || r.op == LSU_LW);
    is_st = (r.itype == INST_STORE) && (r.op == LSU_SB || r.op == LSU_SH || r.op == LSU_SW);
    sign_ext = (r.op == LSU_LB) || (r.op == LSU_LH);
    case (r.op)
      LSU_LB, LSU_LBU, LSU_SB: nbytes = 1;
      LSU_LH, LSU_LHU, LSU_SH: nbytes = 2;
      default:                 nbytes = 4;
    endcase
    mis = (is_ld || is_st) && ((nbytes == 2 && addr[0]) || (nbytes == 4 && addr[1:0] != 2'b00));

    active_ax.addr = addr;
    active_ax.id = '0;
    active_ax.len = '0;
    active_ax.size = (nbytes == 1) ? SIZE_BYTE : (nbytes == 2) ? SIZE_HALF : SIZE_WORD;
    active_ax.burst = `AXI_BURST_INCR;
    r.exp_aw = is_st ? active_ax : '0;
    r.exp_ar = is_ld ? active_ax : '0;
    r.exp_mis = mis;

    r.exp_w = '0;
    if (is_st && !mis) begin
      for (i = 0; i < nbytes; i++) begin
        r.exp_w.data[8*(off+i) +: 8] = r.rs2[8*i +: 8];
        r.exp_w.strb[off+i] = 1'b1;
      end
    end

    // Held result only moves on a strobe with an aligned load
    if (is_ld && !mis && r.we) begin
      val = '0;
      for (i = 0; i < nbytes; i++) begin
        val[8*i +: 8] = r.rdata[8*(off+i) +: 8];
      end
      if (sign_ext && val[8*nbytes-1]) begin
        for (i = nbytes; i < 4; i++) begin
          val[8*i +: 8] = 8'hff;
        end
      end
      model_result = val;
    end
    r.exp_result = model_result;
  endtask

  task automatic add_row(input lsu_op_e op, input inst_type_e itype,
                         input logic [2:0] off, input logic we);
    row_t r;

    r = '0;
    r.op = op;
    r.itype = itype;
    r.rs1 = $urandom & 32'hffff_fff8;
    // Offset of a multiple of 8, sometimes negative, keeps the lane at off
    r.imm = {29'd0, off} + 32'(8 * ($urandom % 4)) - 32'd16;
    r.rs2 = $urandom;
    r.rdata = {$urandom, $urandom};
    r.we = we;
    build_expected(r);
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic apply_row(input int idx);
    row_t r;

    r = rows[idx];
    cur_row = idx;
    @(posedge clock);
    inst_type_i <= r.itype;
    lsu_op_i <= r.op;
    rs1_data_i <= r.rs1;
    imm_i <= r.imm;
    rs2_data_i <= r.rs2;
    rdata_i <= r.rdata;
    rdata_we_i <= 1'b0;
    @(negedge clock);
    check_value("aw_o", aw_o, r.exp_aw);
    check_value("ar_o", ar_o, r.exp_ar);
    check_value("w_o", w_o, r.exp_w);
    check_value("misalign_o", misalign_o, r.exp_mis);
    @(posedge clock);
    rdata_we_i <= r.we;
    @(posedge clock);
    rdata_we_i <= 1'b0;
    @(negedge clock);
    check_value("mem_result_o", mem_result_o, r.exp_result);
  endtask

  task automatic check_reset_state();
    check_value("aw_o", aw_o, '0);
    check_value("ar_o", ar_o, '0);
    check_value("w_o", w_o, '0);
    check_value("misalign_o", misalign_o, 1'b0);
    check_value("mem_result_o", mem_result_o, '0);
  endtask

  initial begin
    int unsigned seed_ret;
    int k;

    seed_ret = $urandom(35);

    // A misaligned store is held during reset and must not show
    reset = 1'b0;
    inst_type_i = INST_STORE;
    lsu_op_i = LSU_SW;
    rs1_data_i = 32'h0000_1003;
    imm_i = 32'd0;
    rs2_data_i = 32'hdead_beef;
    rdata_i = 64'h0123_4567_89ab_cdef;
    rdata_we_i = 1'b0;

    for (k = 0; k < 8; k++) begin
      add_row(LSU_SB, INST_STORE, 3'(k), 1'b0);
      add_row(LSU_SH, INST_STORE, 3'(k), 1'b0);
      add_row(LSU_SW, INST_STORE, 3'(k), 1'b0);
      add_row(LSU_LB, INST_LOAD, 3'(k), 1'b1);
      add_row(LSU_LBU, INST_LOAD, 3'(k), 1'b1);
    end
    for (k = 0; k < 8; k += 2) begin
      add_row(LSU_LH, INST_LOAD, 3'(k), 1'b1);
      add_row(LSU_LHU, INST_LOAD, 3'(k), 1'b1);
    end
    for (k = 0; k < 8; k += 4) begin
      add_row(LSU_LW, INST_LOAD, 3'(k), 1'b1);
    end
    // Misaligned loads with a strobe
    add_row(LSU_LH, INST_LOAD, 3'd1, 1'b1);
    add_row(LSU_LHU, INST_LOAD, 3'd7, 1'b1);
    add_row(LSU_LW, INST_LOAD, 3'd2, 1'b1);
    add_row(LSU_LW, INST_LOAD, 3'd5, 1'b1);
    // Idle, mismatched and unstrobed
    add_row(LSU_NONE, INST_LOAD, 3'd0, 1'b0);
    add_row(LSU_NONE, INST_STORE, 3'd3, 1'b0);
    add_row(LSU_SW, INST_LOAD, 3'd0, 1'b0);
    add_row(LSU_LW, INST_STORE, 3'd4, 1'b0);
    add_row(LSU_LB, INST_OTHER, 3'd1, 1'b0);
    add_row(LSU_SB, INST_OTHER, 3'd6, 1'b0);
    add_row(LSU_LW, INST_LOAD, 3'd4, 1'b0);
    table_ready = 1'b1;

    for (k = 0; k < RESET_CYCLES - 1; k++) begin
      @(negedge clock);
      check_reset_state();
      @(posedge clock);
    end
    @(posedge clock);
    reset <= 1'b1;
    inst_type_i <= INST_OTHER;
    lsu_op_i <= LSU_NONE;
    @(negedge clock);
    check_reset_state();

    for (k = 0; k < n_rows; k++) begin
      apply_row(k);
    end

    $display("Rows: %0d, checks: %0d, errors: %0d", n_rows, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Each row takes three cycles, four are allowed
  initial begin
    wait (table_ready);
    #((n_rows * 4 + RESET_CYCLES + 4) * CLK_PERIOD);
    $display("Timeout: the test did not finish in the expected time (row %0d)", cur_row);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* lsu_top.f */
+incdir+source
source/lsu_op_pkg.sv
source/axi_chan_pkg.sv
source/lsu_addr_gen.sv
source/lsu_store_format.sv
source/lsu_load_align.sv
source/lsu_top.sv
tests/lsu_top_tb.sv
